// ==== tb/bomb_game_testdata.txt ====
# code state lives pos_x pos_y; code 0-5 is a button index, 9 waits for the timer
# state 0 idle, 1 playing, 2 defused, 3 boom
0 1 3 0 0
1 1 2 0 0
2 1 2 1 0
3 1 1 1 0
2 1 1 2 0
3 1 1 2 1
3 1 1 2 2
3 1 1 2 3
2 2 1 3 3
5 0 1 3 3
0 1 3 0 0
4 1 2 0 0
1 1 1 0 0
4 3 0 0 0
5 0 0 0 0
0 1 3 0 0
9 3 3 0 0
5 0 3 0 0

// ==== compile.f ====
rtl/game_pkg.sv
rtl/ssdec_pkg.sv
rtl/button_edge_detector.sv
rtl/countdown_timer.sv
rtl/fsm_game_control.sv
rtl/maze.sv
rtl/ssdec_spi_master.sv
rtl/bomb_game.sv
tb/bomb_game_tb.sv

// ==== tb/bomb_game_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bomb game testbench
// file-driven button steps with state checks and
// decoding of the seven-segment serial frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bomb_game_tb;

    // one second must outlast a full frame handshake (about 70 clocks)
    localparam int TICKS_PER_SEC = 100;
    localparam int SCK_DIV = 2;
    localparam int WAIT_CODE = 9;
    localparam int STEP_LIMIT = 50;
    localparam int TIMER_LIMIT = 10000;

    logic                  clk;
    logic                  rst_n;
    logic [5:0]            button;
    logic                  ssdec_ss;
    logic                  ssdec_sck;
    logic                  ssdec_sdi;
    game_pkg::game_state_t game_state;
    logic [1:0]            lives;
    logic [1:0]            pos_x;
    logic [1:0]            pos_y;

    logic [15:0] frames[$];
    logic [15:0] rx_word;
    int          rx_bits;
    logic        last_sck;

    bomb_game #(
        .TICKS_PER_SEC(TICKS_PER_SEC),
        .SCK_DIV(SCK_DIV)
    ) bomb_game_inst (
        .clk(clk),
        .rst_n(rst_n),
        .button(button),
        .ssdec_ss(ssdec_ss),
        .ssdec_sck(ssdec_sck),
        .ssdec_sdi(ssdec_sdi),
        .game_state(game_state),
        .lives(lives),
        .pos_x(pos_x),
        .pos_y(pos_y)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // sck is a registered output, so sample it away from the rising clock
    always @(negedge clk) begin
        if (!rst_n || ssdec_ss) begin
            rx_bits = 0;
        end else if (ssdec_sck && !last_sck) begin
            rx_word = {rx_word[14:0], ssdec_sdi};
            rx_bits = rx_bits + 1;
            if (rx_bits == 16) begin
                frames.push_back(rx_word);
                rx_bits = 0;
            end
        end
        last_sck = ssdec_sck;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        stop_with_failure($sformatf("Fail at %0t: %s is %0d, expected %0d",
            $time, name, got, exp));
    endtask

    // mark A, then m, s tens, s ones
    function automatic logic [15:0] clock_frame(input int secs);
        int m;
        int st;
        int so;
        m = secs / 60;
        st = (secs % 60) / 10;
        so = secs % 10;
        return {4'hA, 4'(m), 4'(st), 4'(so)};
    endfunction

    function automatic bit outputs_match(input int st, input int lv, input int x, input int y);
        return (int'(game_state) == st) && (int'(lives) == lv) &&
            (int'(pos_x) == x) && (int'(pos_y) == y);
    endfunction

    task automatic press_button(input int idx);
        button[idx] = 1'b1;
        repeat (2) @(negedge clk);
        button[idx] = 1'b0;
    endtask

    task automatic wait_link_idle();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < 100 && waited < 2000) begin
            @(negedge clk);
            waited++;
            if (ssdec_ss)
                quiet++;
            else
                quiet = 0;
        end
        assert (quiet >= 100)
        else stop_with_failure("the seven-segment link never went idle");
    endtask

    task automatic check_countdown_frames();
        int waited;
        waited = 0;
        while (frames.size() < 60 && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        assert (frames.size() >= 60)
        else stop_with_failure($sformatf("only %0d timer frames arrived before the timeout",
            frames.size()));
        foreach (frames[i]) begin
            assert (frames[i][15:12] == 4'hA)
            else stop_with_failure($sformatf("Fail at %0t: frame %0d mark is %h, expected a",
                $time, i, frames[i][15:12]));
        end
        // 0:59 down to 0:00, one second apart
        for (int i = 0; i < 60; i++) begin
            assert (frames[i] == clock_frame(59 - i))
            else stop_with_failure($sformatf("Fail at %0t: frame %0d is %h, expected %h",
                $time, i, frames[i], clock_frame(59 - i)));
        end
    endtask

    task automatic run_step(input int code, input int st, input int lv, input int x,
                            input int y);
        int limit;
        int waited;
        limit = STEP_LIMIT;
        waited = 0;
        if (code == 0) begin
            // a round starts from a quiet link so its frames stand alone
            wait_link_idle();
            frames.delete();
        end
        if (code == WAIT_CODE)
            limit = TIMER_LIMIT;
        else if (code >= 0 && code <= 5)
            press_button(code);
        else
            stop_with_failure($sformatf("unknown button code %0d in the test data", code));
        while (!outputs_match(st, lv, x, y) && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (int'(game_state) == st) else report_mismatch("game_state", game_state, st);
        assert (int'(lives) == lv) else report_mismatch("lives", lives, lv);
        assert (int'(pos_x) == x) else report_mismatch("pos_x", pos_x, x);
        assert (int'(pos_y) == y) else report_mismatch("pos_y", pos_y, y);
        if (code == WAIT_CODE)
            check_countdown_frames();
        // let the released button settle through the sync flops
        repeat (3) @(negedge clk);
    endtask

    initial begin
        int fd;
        int n;
        int code;
        int st;
        int lv;
        int x;
        int y;
        int steps;
        int lines;
        int waited;
        reg [8*128-1:0] line_buf;

        rst_n = 1'b0;
        button = '0;
        last_sck = 1'b0;
        rx_bits = 0;
        rx_word = '0;
        steps = 0;
        lines = 0;
        waited = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // first frame after reset shows 1:00
        while (frames.size() == 0 && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        assert (frames.size() > 0) else stop_with_failure("no frame was sent after reset");
        assert (frames[0] == clock_frame(60))
        else stop_with_failure($sformatf("Fail at %0t: first frame is %h, expected %h",
            $time, frames[0], clock_frame(60)));

        fd = $fopen("tb/bomb_game_testdata.txt", "r");
        assert (fd != 0) else stop_with_failure("could not open the test data file");
        while (!$feof(fd) && lines < 200) begin
            lines++;
            n = $fscanf(fd, " %d %d %d %d %d", code, st, lv, x, y);
            if (n == 5) begin
                run_step(code, st, lv, x, y);
                steps++;
            end else if (!$feof(fd)) begin
                // comment line
                n = $fgets(line_buf, fd);
            end
        end
        $fclose(fd);
        assert (steps > 0) else stop_with_failure("the test data file held no steps");

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== rtl/bomb_game.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bomb game top
// buttons, game control, maze, countdown timer and
// the seven-segment serial link
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bomb_game #(
    parameter int TICKS_PER_SEC = 10_000_000,
    parameter int SCK_DIV = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [5:0]            button,
    output logic                  ssdec_ss,
    output logic                  ssdec_sck,
    output logic                  ssdec_sdi,
    output game_pkg::game_state_t game_state,
    output logic [1:0]            lives,
    output logic [1:0]            pos_x,
    output logic [1:0]            pos_y
);

    logic [5:0]              press;
    logic                    strobe;
    logic                    wall_hit;
    logic                    at_flag;
    logic                    time_up;
    logic                    round_req;
    logic                    round_ack;
    logic                    timer_run;
    logic                    frame_req;
    logic                    frame_ack;
    ssdec_pkg::ssdec_frame_t frame;

    button_edge_detector button_edge_detector_0 (
        .clk(clk),
        .rst_n(rst_n),
        .button(button),
        .press(press),
        .strobe(strobe)
    );

    fsm_game_control fsm_game_control_0 (
        .clk(clk),
        .rst_n(rst_n),
        .press(press),
        .strobe(strobe),
        .wall_hit(wall_hit),
        .at_flag(at_flag),
        .time_up(time_up),
        .round_req(round_req),
        .round_ack(round_ack),
        .timer_run(timer_run),
        .game_state(game_state),
        .lives(lives)
    );

    maze maze_0 (
        .clk(clk),
        .rst_n(rst_n),
        .press(press),
        .strobe(strobe),
        .game_state(game_state),
        .round_req(round_req),
        .round_ack(round_ack),
        .pos_x(pos_x),
        .pos_y(pos_y),
        .wall_hit(wall_hit),
        .at_flag(at_flag)
    );

    countdown_timer #(
        .TICKS_PER_SEC(TICKS_PER_SEC)
    ) countdown_timer_0 (
        .clk(clk),
        .rst_n(rst_n),
        .run(timer_run),
        .time_up(time_up),
        .frame_req(frame_req),
        .frame_ack(frame_ack),
        .frame(frame)
    );

    ssdec_spi_master #(
        .SCK_DIV(SCK_DIV)
    ) ssdec_spi_master_0 (
        .clk(clk),
        .rst_n(rst_n),
        .frame_req(frame_req),
        .frame_ack(frame_ack),
        .frame(frame),
        .ss(ssdec_ss),
        .sck(ssdec_sck),
        .sdi(ssdec_sdi)
    );

endmodule

// ==== rtl/ssdec_spi_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssdec SPI master
// shifts one 16-bit timer frame, MSB first, per
// req/ack handshake to the seven-segment decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ssdec_spi_master #(
    parameter int SCK_DIV = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    frame_req,
    output logic                    frame_ack,
    input  ssdec_pkg::ssdec_frame_t frame,
    output logic                    ss,
    output logic                    sck,
    output logic                    sdi
);

    localparam int NBITS = ssdec_pkg::FRAME_BITS;
    localparam int DIV_W = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;
    localparam int BIT_W = $clog2(NBITS);

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_LOAD = 2'd1;
    localparam logic [1:0] M_SHIFT = 2'd2;
    localparam logic [1:0] M_DONE = 2'd3;

    logic [1:0]              phase;
    logic [DIV_W-1:0]        div_cnt;
    logic [BIT_W-1:0]        bit_cnt;
    logic                    half_done;
    logic                    take;
    ssdec_pkg::ssdec_frame_t shift_q;

    assign half_done = (div_cnt == DIV_W'(SCK_DIV - 1));
    assign take = (phase == M_IDLE) && frame_req && !frame_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= M_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            ss <= 1'b1;
            sck <= 1'b0;
            frame_ack <= 1'b0;
        end else begin
            case (phase)
                M_IDLE: begin
                    if (take)
                        phase <= M_LOAD;
                end
                M_LOAD: begin
                    ss <= 1'b0;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    phase <= M_SHIFT;
                end
                M_SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (half_done) begin
                        div_cnt <= '0;
                        sck <= ~sck;
                        // falling edge closes a bit
                        if (sck) begin
                            if (bit_cnt == BIT_W'(NBITS - 1)) begin
                                ss <= 1'b1;
                                frame_ack <= 1'b1;
                                phase <= M_DONE;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    if (!frame_req) begin
                        frame_ack <= 1'b0;
                        phase <= M_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            shift_q <= frame;
        else if (phase == M_SHIFT && half_done && sck)
            shift_q.raw <= {shift_q.raw[NBITS-2:0], 1'b0};
    end

    // next bit appears right after each falling sck
    assign sdi = shift_q.raw[NBITS-1] & ~ss;

    sck_idle_low: assert property (@(posedge clk) disable iff (!rst_n) ss |-> !sck);

endmodule

// ==== rtl/maze.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// maze
// fixed 4x4 wall map, player movement, wall hits
// and flag arrival
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module maze (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [5:0]            press,
    input  logic                  strobe,
    input  game_pkg::game_state_t game_state,
    input  logic                  round_req,
    output logic                  round_ack,
    output logic [1:0]            pos_x,
    output logic [1:0]            pos_y,
    output logic                  wall_hit,
    output logic                  at_flag
);

    localparam int CELLS = game_pkg::GRID_SIZE * game_pkg::GRID_SIZE;

    // open sides per cell {left, down, right, up}, index y*4+x
    localparam logic [3:0] OPEN_MAP [CELLS] = '{
        4'b0110, 4'b1010, 4'b1110, 4'b1100,
        4'b0111, 4'b1110, 4'b1101, 4'b0101,
        4'b0111, 4'b1011, 4'b1111, 4'b1001,
        4'b0011, 4'b1010, 4'b1011, 4'b1000
    };

    logic       window;
    logic       dir_req;
    logic [1:0] dir;
    logic [1:0] next_x;
    logic [1:0] next_y;
    logic [3:0] cell_open;

    // priority up, right, down, left
    always_comb begin
        dir_req = 1'b1;
        dir = 2'd0;
        next_x = pos_x;
        next_y = pos_y;
        if (press[game_pkg::BTN_UP]) begin
            dir = 2'd0;
            next_y = pos_y - 2'd1;
        end else if (press[game_pkg::BTN_RIGHT]) begin
            dir = 2'd1;
            next_x = pos_x + 2'd1;
        end else if (press[game_pkg::BTN_DOWN]) begin
            dir = 2'd2;
            next_y = pos_y + 2'd1;
        end else if (press[game_pkg::BTN_LEFT]) begin
            dir = 2'd3;
            next_x = pos_x - 2'd1;
        end else begin
            dir_req = 1'b0;
        end
    end

    // grid edges are closed in the map, so wraparound never lands
    assign cell_open = OPEN_MAP[{pos_y, pos_x}];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos_x <= game_pkg::START_X;
            pos_y <= game_pkg::START_Y;
            round_ack <= 1'b0;
            window <= 1'b0;
            wall_hit <= 1'b0;
        end else begin
            wall_hit <= 1'b0;
            if (round_req && !round_ack) begin
                pos_x <= game_pkg::START_X;
                pos_y <= game_pkg::START_Y;
                window <= 1'b1;
                round_ack <= 1'b1;
            end else begin
                if (!round_req)
                    round_ack <= 1'b0;
                if (game_state != game_pkg::ST_PLAYING) begin
                    window <= 1'b0;
                end else if (window && strobe && dir_req) begin
                    if (cell_open[dir]) begin
                        pos_x <= next_x;
                        pos_y <= next_y;
                    end else begin
                        wall_hit <= 1'b1;
                    end
                end
            end
        end
    end

    assign at_flag = (pos_x == game_pkg::DEST_X) && (pos_y == game_pkg::DEST_Y);

endmodule

// ==== rtl/fsm_game_control.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// game control FSM
// idle / playing / defused / boom, life counter
// and round start request toward the maze
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fsm_game_control (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [5:0]            press,
    input  logic                  strobe,
    input  logic                  wall_hit,
    input  logic                  at_flag,
    input  logic                  time_up,
    output logic                  round_req,
    input  logic                  round_ack,
    output logic                  timer_run,
    output game_pkg::game_state_t game_state,
    output logic [1:0]            lives
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            game_state <= game_pkg::ST_IDLE;
            lives <= game_pkg::LIVES_START;
            round_req <= 1'b0;
        end else begin
            if (round_req && round_ack)
                round_req <= 1'b0;

            case (game_state)
                game_pkg::ST_IDLE: begin
                    if (strobe && press[game_pkg::BTN_SELECT]) begin
                        game_state <= game_pkg::ST_PLAYING;
                        lives <= game_pkg::LIVES_START;
                        round_req <= 1'b1;
                    end
                end
                game_pkg::ST_PLAYING: begin
                    // maze status is stale until the round start completes
                    if (!round_req) begin
                        if (time_up) begin
                            game_state <= game_pkg::ST_BOOM;
                        end else if (wall_hit) begin
                            lives <= lives - 2'd1;
                            if (lives == 2'd1)
                                game_state <= game_pkg::ST_BOOM;
                        end else if (at_flag) begin
                            game_state <= game_pkg::ST_DEFUSED;
                        end
                    end
                end
                default: begin
                    if (strobe && press[game_pkg::BTN_BACK])
                        game_state <= game_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign timer_run = (game_state == game_pkg::ST_PLAYING);

    lives_reload_only: assert property (@(posedge clk) disable iff (!rst_n)
        (lives > $past(lives)) |->
            ($past(game_state) == game_pkg::ST_IDLE) && (game_state == game_pkg::ST_PLAYING));

endmodule

// ==== rtl/countdown_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// countdown timer
// counts m:ss down to 0:00 while run is high and
// offers each new digit set to the ssdec master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module countdown_timer #(
    parameter int TICKS_PER_SEC = 10_000_000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    output logic                    time_up,
    output logic                    frame_req,
    input  logic                    frame_ack,
    output ssdec_pkg::ssdec_frame_t frame
);

    localparam int TICK_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

    logic [TICK_W-1:0] tick_cnt;
    logic [3:0] min_q, sec_ten_q, sec_one_q;
    logic [3:0] min_d, sec_ten_d, sec_one_d;
    logic at_zero;
    logic sec_tick;
    logic changed;
    logic dirty;
    logic offer;

    assign at_zero = (min_q == 4'd0) && (sec_ten_q == 4'd0) && (sec_one_q == 4'd0);
    assign sec_tick = run && !at_zero && (tick_cnt == TICK_W'(TICKS_PER_SEC - 1));

    // next digits, borrow from the left
    always_comb begin
        min_d = min_q;
        sec_ten_d = sec_ten_q;
        sec_one_d = sec_one_q;
        if (!run) begin
            min_d = game_pkg::START_MIN;
            sec_ten_d = game_pkg::START_SEC_TEN;
            sec_one_d = game_pkg::START_SEC_ONE;
        end else if (sec_tick) begin
            if (sec_one_q != 4'd0) begin
                sec_one_d = sec_one_q - 4'd1;
            end else if (sec_ten_q != 4'd0) begin
                sec_one_d = 4'd9;
                sec_ten_d = sec_ten_q - 4'd1;
            end else begin
                sec_one_d = 4'd9;
                sec_ten_d = 4'd5;
                min_d = min_q - 4'd1;
            end
        end
    end

    assign changed = {min_d, sec_ten_d, sec_one_d} != {min_q, sec_ten_q, sec_one_q};
    // new offer only once the previous handshake has fully closed
    assign offer = dirty && !frame_req && !frame_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            min_q <= game_pkg::START_MIN;
            sec_ten_q <= game_pkg::START_SEC_TEN;
            sec_one_q <= game_pkg::START_SEC_ONE;
            time_up <= 1'b0;
            dirty <= 1'b1;
            frame_req <= 1'b0;
        end else begin
            if (!run || at_zero || sec_tick)
                tick_cnt <= '0;
            else
                tick_cnt <= tick_cnt + 1'b1;
            min_q <= min_d;
            sec_ten_q <= sec_ten_d;
            sec_one_q <= sec_one_d;
            time_up <= run && ({min_d, sec_ten_d, sec_one_d} == 12'd0);
            dirty <= changed || (dirty && !offer);
            if (offer)
                frame_req <= 1'b1;
            else if (frame_ack)
                frame_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (offer) begin
            frame.fields.mark <= ssdec_pkg::FRAME_MARK;
            frame.fields.min <= min_q;
            frame.fields.sec_ten <= sec_ten_q;
            frame.fields.sec_one <= sec_one_q;
        end
    end

    // master may only acknowledge an open request
    ack_only_on_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(frame_ack) |-> frame_req);

endmodule

// ==== rtl/button_edge_detector.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// button edge detector
// two-flop sync on all six buttons, one-cycle press
// pulse per rising edge and a common strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module button_edge_detector (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [5:0] button,
    output logic [5:0] press,
    output logic       strobe
);

    logic [5:0] sync_a;
    logic [5:0] sync_b;
    logic [5:0] last_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_a <= '0;
            sync_b <= '0;
            last_b <= '0;
            press <= '0;
        end else begin
            sync_a <= button;
            sync_b <= sync_a;
            last_b <= sync_b;
            // rising edge of the synchronized level
            press <= sync_b & ~last_b;
        end
    end

    assign strobe = |press;

endmodule

// ==== rtl/ssdec_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// seven-segment decoder package
// serial frame layout sent to the external decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ssdec_pkg;

    localparam int unsigned FRAME_BITS = 16;

    // top nibble of every frame
    localparam logic [3:0] FRAME_MARK = 4'hA;

    typedef struct packed {
        logic [3:0] mark;
        logic [3:0] min;
        logic [3:0] sec_ten;
        logic [3:0] sec_one;
    } ssdec_fields_t;

    // timer writes the digit fields, the master shifts the raw word
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        ssdec_fields_t fields;
    } ssdec_frame_t;

endpackage

// ==== rtl/game_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// game package
// game states, lives, grid geometry, timer start
// value and button bit positions for the bomb game
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package game_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PLAYING,
        ST_DEFUSED,
        ST_BOOM
    } game_state_t;

    localparam logic [1:0] LIVES_START = 2'd3;

    // 4 by 4 maze, 2-bit coordinates
    localparam int unsigned GRID_SIZE = 4;
    localparam logic [1:0] START_X = 2'd0;
    localparam logic [1:0] START_Y = 2'd0;
    localparam logic [1:0] DEST_X = 2'd3;
    localparam logic [1:0] DEST_Y = 2'd3;

    // countdown starts at 1:00
    localparam logic [3:0] START_MIN = 4'd1;
    localparam logic [3:0] START_SEC_TEN = 4'd0;
    localparam logic [3:0] START_SEC_ONE = 4'd0;

    localparam int unsigned BTN_SELECT = 0;
    localparam int unsigned BTN_UP = 1;
    localparam int unsigned BTN_RIGHT = 2;
    localparam int unsigned BTN_DOWN = 3;
    localparam int unsigned BTN_LEFT = 4;
    localparam int unsigned BTN_BACK = 5;

endpackage
